// File: rtl/ntt_cfg.svh
`ifndef NTT_CFG_SVH
`define NTT_CFG_SVH

// Kyber-style prime modulus
`define NTT_Q 12'd3329

// One reduced coefficient, and a packed a/b pair
`define NTT_COEFF_W 12
`define NTT_DATA_W 24

// Store-side outputs per block, flagged by o_sw_lst
`define NTT_BLOCK_PAIRS 8

// Barrett constants with M = floor(2^K / Q) and K = NTT_DATA_W
`define NTT_BARRETT_K 24
`define NTT_BARRETT_M 13'd5039

`endif

// File: rtl/ntt_pkg.sv
`include "ntt_cfg.svh"

package ntt_pkg;

    typedef enum logic [1:0] {
        MODE_FFT  = 2'b00,
        MODE_IFFT = 2'b01,
        MODE_NTT  = 2'b10,
        MODE_INTT = 2'b11
    } mode_e;

    typedef logic [`NTT_COEFF_W-1:0] coeff_t;
    typedef logic [`NTT_DATA_W-1:0] word_t;

    // Inputs must already be reduced
    function automatic coeff_t mod_add(input coeff_t x, input coeff_t y);
        logic [`NTT_COEFF_W:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= {1'b0, `NTT_Q}) begin
            s = s - {1'b0, `NTT_Q};
        end
        return s[`NTT_COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_sub(input coeff_t x, input coeff_t y);
        logic [`NTT_COEFF_W:0] d;
        d = {1'b0, x} - {1'b0, y};
        // Fold a wrapped negative back into range
        if (x < y) begin
            d = d + {1'b0, `NTT_Q};
        end
        return d[`NTT_COEFF_W-1:0];
    endfunction

endpackage

// File: rtl/operand_join.sv
module operand_join (
    input  logic            clk,
    input  logic            rstn,

    input  logic            i_ld_vld,
    output logic            o_ld_rdy,
    input  ntt_pkg::word_t  i_ld_dat,

    input  logic            i_coef_vld,
    output logic            o_coef_rdy,
    input  ntt_pkg::coeff_t i_coef_dat,

    input  ntt_pkg::mode_e  i_mode,
    input  logic            i_decode,

    output logic            o_vld,
    input  logic            i_rdy,
    output ntt_pkg::coeff_t o_a,
    output ntt_pkg::coeff_t o_b,
    output ntt_pkg::coeff_t o_w,
    output ntt_pkg::mode_e  o_mode
);
    import ntt_pkg::*;

    mode_e  mode_q;
    logic   mode_ok;
    logic   slot_free;
    logic   accept;
    logic   vld_q;
    coeff_t a_q;
    coeff_t b_q;
    coeff_t w_q;
    mode_e  item_mode_q;

    // Kernel mode register, only NTT and INTT are served here
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mode_q <= MODE_FFT;
        end else if (i_decode) begin
            mode_q <= i_mode;
        end
    end

    assign mode_ok   = (mode_q == MODE_NTT) || (mode_q == MODE_INTT);
    assign slot_free = !vld_q || i_rdy;

    // Both streams move on the same edge
    assign accept     = i_ld_vld && i_coef_vld && mode_ok && slot_free;
    assign o_ld_rdy   = accept;
    assign o_coef_rdy = accept;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= 1'b0;
        end else if (slot_free) begin
            vld_q <= accept;
        end
    end

    // a sits in the low half of the load word
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q         <= i_ld_dat[$bits(coeff_t)-1:0];
            b_q         <= i_ld_dat[$bits(word_t)-1 -: $bits(coeff_t)];
            w_q         <= i_coef_dat;
            item_mode_q <= mode_q;
        end
    end

    assign o_vld  = vld_q;
    assign o_a    = a_q;
    assign o_b    = b_q;
    assign o_w    = w_q;
    assign o_mode = item_mode_q;

    a_join_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        o_vld && !i_rdy |=> o_vld && $stable({o_a, o_b, o_w, o_mode})
    ) else $error("join register changed while stalled");

endmodule

// File: rtl/bfly_pre_stage.sv
module bfly_pre_stage (
    input  logic            clk,
    input  logic            rstn,

    input  logic            i_vld,
    output logic            o_rdy,
    input  ntt_pkg::coeff_t i_a,
    input  ntt_pkg::coeff_t i_b,
    input  ntt_pkg::coeff_t i_w,
    input  ntt_pkg::mode_e  i_mode,

    output logic            o_vld,
    input  logic            i_rdy,
    output ntt_pkg::coeff_t o_a,
    output ntt_pkg::coeff_t o_b,
    output ntt_pkg::coeff_t o_w,
    output ntt_pkg::mode_e  o_mode
);
    import ntt_pkg::*;

    logic   take;
    logic   vld_q;
    coeff_t a_q;
    coeff_t b_q;
    coeff_t w_q;
    mode_e  mode_q;

    assign o_rdy = !vld_q || i_rdy;
    assign take  = i_vld && o_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= 1'b0;
        end else if (o_rdy) begin
            vld_q <= i_vld;
        end
    end

    // Gentleman-Sande does the add/sub before the twiddle
    always_ff @(posedge clk) begin
        if (take) begin
            if (i_mode == MODE_INTT) begin
                a_q <= mod_add(i_a, i_b);
                b_q <= mod_sub(i_a, i_b);
            end else begin
                a_q <= i_a;
                b_q <= i_b;
            end
            w_q    <= i_w;
            mode_q <= i_mode;
        end
    end

    assign o_vld  = vld_q;
    assign o_a    = a_q;
    assign o_b    = b_q;
    assign o_w    = w_q;
    assign o_mode = mode_q;

endmodule

// File: rtl/bfly_mul_stage.sv
`include "ntt_cfg.svh"

module bfly_mul_stage (
    input  logic            clk,
    input  logic            rstn,

    input  logic            i_vld,
    output logic            o_rdy,
    input  ntt_pkg::coeff_t i_a,
    input  ntt_pkg::coeff_t i_b,
    input  ntt_pkg::coeff_t i_w,
    input  ntt_pkg::mode_e  i_mode,

    output logic            o_vld,
    input  logic            i_rdy,
    output ntt_pkg::coeff_t o_a,
    output ntt_pkg::coeff_t o_b,
    output ntt_pkg::coeff_t o_w,
    output ntt_pkg::mode_e  o_mode
);
    import ntt_pkg::*;

    logic [`NTT_DATA_W-1:0]              prod_w;
    logic [`NTT_DATA_W+`NTT_COEFF_W:0]   qhat_full;
    coeff_t                              qhat;
    logic [`NTT_DATA_W-1:0]              rem;
    logic [`NTT_DATA_W-1:0]              rem_sub;
    coeff_t                              b_red;
    logic                                take;
    logic                                vld_q;
    coeff_t                              a_q;
    coeff_t                              b_q;
    coeff_t                              w_q;
    mode_e                               mode_q;

    // Barrett reduction needs one correction step since the product is below 2^K
    assign prod_w    = i_b * i_w;
    assign qhat_full = prod_w * `NTT_BARRETT_M;
    assign qhat      = qhat_full[`NTT_BARRETT_K +: `NTT_COEFF_W];
    assign rem       = prod_w - qhat * `NTT_Q;
    assign rem_sub   = rem - `NTT_Q;
    assign b_red     = (rem >= `NTT_Q) ? rem_sub[`NTT_COEFF_W-1:0] : rem[`NTT_COEFF_W-1:0];

    assign o_rdy = !vld_q || i_rdy;
    assign take  = i_vld && o_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= 1'b0;
        end else if (o_rdy) begin
            vld_q <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            a_q    <= i_a;
            b_q    <= b_red;
            w_q    <= i_w;
            mode_q <= i_mode;
        end
    end

    assign o_vld  = vld_q;
    assign o_a    = a_q;
    assign o_b    = b_q;
    assign o_w    = w_q;
    assign o_mode = mode_q;

    // Reduction above is only exact for reduced operands
    a_mul_range: assert property (
        @(posedge clk) disable iff (!rstn)
        take |-> (i_b < `NTT_Q) && (i_w < `NTT_Q)
    ) else $error("multiplier operand not reduced");

endmodule

// File: rtl/bfly_post_stage.sv
`include "ntt_cfg.svh"

module bfly_post_stage (
    input  logic            clk,
    input  logic            rstn,

    input  logic            i_vld,
    output logic            o_rdy,
    input  ntt_pkg::coeff_t i_a,
    input  ntt_pkg::coeff_t i_b,
    input  ntt_pkg::mode_e  i_mode,

    output logic            o_sw_vld,
    input  logic            i_sw_rdy,
    output ntt_pkg::word_t  o_sw_dat,
    output logic            o_sw_lst
);
    import ntt_pkg::*;

    logic                                   take;
    logic                                   vld_q;
    logic                                   lst_q;
    logic [$clog2(`NTT_BLOCK_PAIRS)-1:0]    blk_cnt;
    coeff_t                                 a_q;
    coeff_t                                 b_q;

    assign o_rdy = !vld_q || i_sw_rdy;
    assign take  = i_vld && o_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q <= 1'b0;
        end else if (o_rdy) begin
            vld_q <= i_vld;
        end
    end

    // Position within the current block
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            blk_cnt <= '0;
            lst_q   <= 1'b0;
        end else if (take) begin
            lst_q <= (blk_cnt == `NTT_BLOCK_PAIRS - 1);
            if (blk_cnt == `NTT_BLOCK_PAIRS - 1) begin
                blk_cnt <= '0;
            end else begin
                blk_cnt <= blk_cnt + 1'b1;
            end
        end
    end

    // Cooley-Tukey add/sub on a and t = w*b
    always_ff @(posedge clk) begin
        if (take) begin
            if (i_mode == MODE_NTT) begin
                a_q <= mod_add(i_a, i_b);
                b_q <= mod_sub(i_a, i_b);
            end else begin
                a_q <= i_a;
                b_q <= i_b;
            end
        end
    end

    assign o_sw_vld = vld_q;
    assign o_sw_dat = {b_q, a_q};
    assign o_sw_lst = vld_q && lst_q;

    a_store_range: assert property (
        @(posedge clk) disable iff (!rstn)
        o_sw_vld |-> (o_sw_dat[`NTT_COEFF_W-1:0] < `NTT_Q)
                  && (o_sw_dat[`NTT_DATA_W-1 -: `NTT_COEFF_W] < `NTT_Q)
    ) else $error("store word holds an unreduced coefficient");

endmodule

// File: rtl/kernel_top.sv
module kernel_top (
    input  logic            clk,
    input  logic            rstn,

    input  logic            i_ld_vld,
    output logic            o_ld_rdy,
    input  ntt_pkg::word_t  i_ld_dat,

    input  logic            i_coef_vld,
    output logic            o_coef_rdy,
    input  ntt_pkg::coeff_t i_coef_dat,

    input  ntt_pkg::mode_e  i_mode,
    input  logic            i_decode,

    output logic            o_sw_vld,
    input  logic            i_sw_rdy,
    output ntt_pkg::word_t  o_sw_dat,
    output logic            o_sw_lst
);
    import ntt_pkg::*;

    // Join register to pre stage
    logic   j_vld;
    logic   j_rdy;
    coeff_t j_a;
    coeff_t j_b;
    coeff_t j_w;
    mode_e  j_mode;

    // Pre stage to multiplier
    logic   p_vld;
    logic   p_rdy;
    coeff_t p_a;
    coeff_t p_b;
    coeff_t p_w;
    mode_e  p_mode;

    // Multiplier to post stage
    logic   m_vld;
    logic   m_rdy;
    coeff_t m_a;
    coeff_t m_b;
    mode_e  m_mode;

    operand_join u_join (
        .clk        (clk),
        .rstn       (rstn),
        .i_ld_vld   (i_ld_vld),
        .o_ld_rdy   (o_ld_rdy),
        .i_ld_dat   (i_ld_dat),
        .i_coef_vld (i_coef_vld),
        .o_coef_rdy (o_coef_rdy),
        .i_coef_dat (i_coef_dat),
        .i_mode     (i_mode),
        .i_decode   (i_decode),
        .o_vld      (j_vld),
        .i_rdy      (j_rdy),
        .o_a        (j_a),
        .o_b        (j_b),
        .o_w        (j_w),
        .o_mode     (j_mode)
    );

    bfly_pre_stage u_pre (
        .clk    (clk),
        .rstn   (rstn),
        .i_vld  (j_vld),
        .o_rdy  (j_rdy),
        .i_a    (j_a),
        .i_b    (j_b),
        .i_w    (j_w),
        .i_mode (j_mode),
        .o_vld  (p_vld),
        .i_rdy  (p_rdy),
        .o_a    (p_a),
        .o_b    (p_b),
        .o_w    (p_w),
        .o_mode (p_mode)
    );

    // Twiddle is consumed here, so its forwarded copy goes nowhere
    bfly_mul_stage u_mul (
        .clk    (clk),
        .rstn   (rstn),
        .i_vld  (p_vld),
        .o_rdy  (p_rdy),
        .i_a    (p_a),
        .i_b    (p_b),
        .i_w    (p_w),
        .i_mode (p_mode),
        .o_vld  (m_vld),
        .i_rdy  (m_rdy),
        .o_a    (m_a),
        .o_b    (m_b),
        .o_w    (),
        .o_mode (m_mode)
    );

    bfly_post_stage u_post (
        .clk      (clk),
        .rstn     (rstn),
        .i_vld    (m_vld),
        .o_rdy    (m_rdy),
        .i_a      (m_a),
        .i_b      (m_b),
        .i_mode   (m_mode),
        .o_sw_vld (o_sw_vld),
        .i_sw_rdy (i_sw_rdy),
        .o_sw_dat (o_sw_dat),
        .o_sw_lst (o_sw_lst)
    );

endmodule

// File: tests/tb_kernel_top.sv
`include "ntt_cfg.svh"

module tb_kernel_top;
    timeunit 1ns;
    timeprecision 1ps;

    import ntt_pkg::*;

    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 1000;

    logic   clk;
    logic   rstn;
    logic   i_ld_vld;
    logic   o_ld_rdy;
    word_t  i_ld_dat;
    logic   i_coef_vld;
    logic   o_coef_rdy;
    coeff_t i_coef_dat;
    mode_e  i_mode;
    logic   i_decode;
    logic   o_sw_vld;
    logic   i_sw_rdy;
    word_t  o_sw_dat;
    logic   o_sw_lst;

    mode_e  cur_mode;
    word_t  exp_q[$];
    int     cyc;
    int     out_cnt;
    int     last_in_edge;
    int     last_out_edge;
    int     last_wait;
    logic   rand_sw;
    logic   rdy_pat[0:255];
    int     pat_idx;
    logic   stall_q;
    word_t  held_dat;
    logic   held_lst;

    kernel_top UUT (
        .clk        (clk),
        .rstn       (rstn),
        .i_ld_vld   (i_ld_vld),
        .o_ld_rdy   (o_ld_rdy),
        .i_ld_dat   (i_ld_dat),
        .i_coef_vld (i_coef_vld),
        .o_coef_rdy (o_coef_rdy),
        .i_coef_dat (i_coef_dat),
        .i_mode     (i_mode),
        .i_decode   (i_decode),
        .o_sw_vld   (o_sw_vld),
        .i_sw_rdy   (i_sw_rdy),
        .o_sw_dat   (o_sw_dat),
        .o_sw_lst   (o_sw_lst)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Store-side ready is random only while back-pressure is on
    initial begin
        i_sw_rdy = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (rand_sw) begin
                i_sw_rdy = rdy_pat[pat_idx];
                pat_idx  = (pat_idx + 1) % 256;
            end else begin
                i_sw_rdy = 1'b1;
            end
        end
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            stop_with_error($sformatf("Fail at time %0t: %s, got %0h, expected %0h",
                                      $time, what, actual, expected));
        end
    endtask

    // NTT gives a+w*b and a-w*b mod q
    // INTT gives a+b and (a-b)*w mod q
    function automatic word_t expected_result(input mode_e m, input coeff_t a,
                                              input coeff_t b, input coeff_t w);
        int q;
        int ai;
        int bi;
        int wi;
        int t;
        int lo;
        int hi;
        q  = `NTT_Q;
        ai = a;
        bi = b;
        wi = w;
        if (m == MODE_NTT) begin
            t  = (wi * bi) % q;
            lo = (ai + t) % q;
            hi = (ai - t + q) % q;
        end else begin
            lo = (ai + bi) % q;
            hi = (((ai - bi + q) % q) * wi) % q;
        end
        return {hi[`NTT_COEFF_W-1:0], lo[`NTT_COEFF_W-1:0]};
    endfunction

    function automatic coeff_t rand_coeff();
        return coeff_t'($urandom_range(`NTT_Q - 1, 0));
    endfunction

    // Values sampled mid-cycle are the ones the next edge sees
    always @(negedge clk) begin
        if (rstn) begin
            if (stall_q) begin
                check_eq(o_sw_vld, 1'b1, "store valid dropped while stalled");
                check_eq(o_sw_dat, held_dat, "store data changed while stalled");
                check_eq(o_sw_lst, held_lst, "block flag changed while stalled");
            end
            if (!o_sw_vld) begin
                check_eq(o_sw_lst, 1'b0, "block flag without store valid");
            end else if (i_sw_rdy) begin
                if (exp_q.size() == 0) begin
                    stop_with_error("The store stream produced an item that was never sent.");
                end
                check_eq(o_sw_dat, exp_q.pop_front(), "store data");
                check_eq(o_sw_lst, (out_cnt % `NTT_BLOCK_PAIRS) == `NTT_BLOCK_PAIRS - 1,
                         "end-of-block flag");
                out_cnt++;
                last_out_edge = cyc + 1;
            end
            stall_q  = o_sw_vld && !i_sw_rdy;
            held_dat = o_sw_dat;
            held_lst = o_sw_lst;
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic decode_mode(input mode_e m);
        i_mode   = m;
        i_decode = 1'b1;
        @(posedge clk);
        #1;
        i_decode = 1'b0;
        cur_mode = m;
    endtask

    task automatic send_item(input coeff_t a, input coeff_t b, input coeff_t w);
        int waited;
        waited     = 0;
        i_ld_vld   = 1'b1;
        i_ld_dat   = {b, a};
        i_coef_vld = 1'b1;
        i_coef_dat = w;
        @(negedge clk);
        while (!o_ld_rdy) begin
            waited++;
            if (waited > READY_TIMEOUT) begin
                stop_with_error("The input streams never became ready for a pending item.");
            end
            @(negedge clk);
        end
        check_eq(o_coef_rdy, o_ld_rdy, "coefficient ready differs from load ready");
        exp_q.push_back(expected_result(cur_mode, a, b, w));
        last_in_edge = cyc + 1;
        last_wait    = waited;
        @(posedge clk);
        #1;
        i_ld_vld   = 1'b0;
        i_coef_vld = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                stop_with_error("Results were still missing from the store stream.");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic expect_refusal(input string label);
        i_ld_vld   = 1'b1;
        i_ld_dat   = {rand_coeff(), rand_coeff()};
        i_coef_vld = 1'b1;
        i_coef_dat = rand_coeff();
        repeat (20) begin
            @(negedge clk);
            check_eq(o_ld_rdy, 1'b0, {label, ": load ready"});
            check_eq(o_coef_rdy, 1'b0, {label, ": coefficient ready"});
            check_eq(o_sw_vld, 1'b0, {label, ": store valid"});
        end
        @(posedge clk);
        #1;
        i_ld_vld   = 1'b0;
        i_coef_vld = 1'b0;
    endtask

    task automatic fft_modes_refused();
        expect_refusal("after reset");
        decode_mode(MODE_FFT);
        expect_refusal("FFT mode");
        decode_mode(MODE_IFFT);
        expect_refusal("IFFT mode");
    endtask

    task automatic butterfly_stream(input mode_e m);
        decode_mode(m);
        send_item(rand_coeff(), rand_coeff(), rand_coeff());
        wait_drain();
        check_eq(last_out_edge - last_in_edge, 4, "isolated item latency");
        // Range corners
        send_item(`NTT_Q - 1, `NTT_Q - 1, `NTT_Q - 1);
        send_item(0, `NTT_Q - 1, 1);
        repeat (16) begin
            send_item(rand_coeff(), rand_coeff(), rand_coeff());
        end
        wait_drain();
    endtask

    task automatic back_pressure_stream();
        decode_mode(MODE_NTT);
        rand_sw = 1'b1;
        repeat (24) begin
            idle_cycles($urandom_range(2, 0));
            send_item(rand_coeff(), rand_coeff(), rand_coeff());
        end
        wait_drain();
        rand_sw = 1'b0;
    endtask

    task automatic mode_change_in_flight();
        decode_mode(MODE_NTT);
        repeat (4) begin
            send_item(rand_coeff(), rand_coeff(), rand_coeff());
        end
        // Accepted on the decode edge, so still an NTT item
        i_mode   = MODE_INTT;
        i_decode = 1'b1;
        send_item(rand_coeff(), rand_coeff(), rand_coeff());
        i_decode = 1'b0;
        check_eq(last_wait, 0, "item on the decode edge was held back");
        cur_mode = MODE_INTT;
        repeat (7) begin
            send_item(rand_coeff(), rand_coeff(), rand_coeff());
        end
        decode_mode(MODE_NTT);
        repeat (4) begin
            send_item(rand_coeff(), rand_coeff(), rand_coeff());
        end
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'ha8a8));
        rstn          = 1'b0;
        i_ld_vld      = 1'b0;
        i_ld_dat      = '0;
        i_coef_vld    = 1'b0;
        i_coef_dat    = '0;
        i_mode        = MODE_FFT;
        i_decode      = 1'b0;
        cur_mode      = MODE_FFT;
        cyc           = 0;
        out_cnt       = 0;
        last_in_edge  = 0;
        last_out_edge = 0;
        last_wait     = 0;
        rand_sw       = 1'b0;
        pat_idx       = 0;
        stall_q       = 1'b0;
        held_dat      = '0;
        held_lst      = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rdy_pat[i] = $urandom_range(1, 0);
        end
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;

        fft_modes_refused();
        butterfly_stream(MODE_NTT);
        butterfly_stream(MODE_INTT);
        back_pressure_stream();
        mode_change_in_flight();

        // Any stray store item still reaches the monitor here
        idle_cycles(8);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+rtl
rtl/ntt_pkg.sv
rtl/operand_join.sv
rtl/bfly_pre_stage.sv
rtl/bfly_mul_stage.sv
rtl/bfly_post_stage.sv
rtl/kernel_top.sv
tests/tb_kernel_top.sv
